//--- verilog.f
logic/tusca_pkg.sv
logic/dht11_reader.sv
logic/config_receiver.sv
logic/tusca_uc.sv
logic/climate_actuator.sv
logic/tusca.sv
dv/tusca_tb.sv

//--- dv/tusca_tb.sv
module tusca_tb
  import tusca_pkg::*;
();

  // high widths sit right on either side of the bit threshold
  localparam int N_FRAMES    = 14;
  localparam int LOW_CLKS    = 20;
  localparam int HIGH0_CLKS  = BIT_THRESH;
  localparam int HIGH1_CLKS  = BIT_THRESH + 1;
  localparam int FRAME_CLKS  = 40 * (LOW_CLKS + HIGH1_CLKS) + 2 * LOW_CLKS;
  localparam int SERIAL_CLKS = 3 * 5 * 12 * CLKS_PER_BIT;
  localparam int RUN_CLKS    = N_FRAMES * (PERIODO_DELAY + FRAME_CLKS) + SERIAL_CLKS
                             + 4 * SERVO_PERIOD + 1000;

  typedef struct packed {
    logic [2:0] nivel;
    logic [7:0] fan_high;
    logic       rele;
    logic [8:0] servo_high;
  } expected_t;

  logic       clock;
  logic       rst_n;
  logic       start;
  logic       gira;
  logic       rx_serial;
  logic       dht_bus;
  logic       erro_config;
  logic       rele;
  logic       pwm_ventoinha;
  logic       pwm_servo;
  logic       erro_medida;
  logic [2:0] nivel_temperatura;
  config_t    cur_cfg;
  logic [7:0] last_temp;
  logic [7:0] last_hum;
  int         errors = 0;

  tusca u_dut (
    .clock(clock), .rst_n(rst_n), .start(start), .gira(gira),
    .rx_serial(rx_serial), .dht_bus(dht_bus), .erro_config(erro_config),
    .rele(rele), .pwm_ventoinha(pwm_ventoinha), .pwm_servo(pwm_servo),
    .erro_medida(erro_medida), .nivel_temperatura(nivel_temperatura)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  initial begin
    repeat (RUN_CLKS) @(posedge clock);
    $display("watchdog expired after %0d clocks, the run did not finish", RUN_CLKS);
    $display("Done: errors found");
    $fatal(1);
  end

  // expected outputs from the controller rules
  function automatic expected_t predict_outputs(input config_t c, input logic [7:0] temp,
                                                input logic [7:0] hum, input logic gira_in);
    expected_t e;
    int        level;
    level = 0;
    for (int i = 0; i < 4; i++) begin
      if (temp >= c.lim_temp[i]) level++;
    end
    e.nivel      = 3'(level);
    e.fan_high   = 8'(level * DUTY_STEP);
    e.rele       = (hum < c.lim_umidade);
    e.servo_high = gira_in ? 9'(SERVO_MAX) : 9'(SERVO_MIN);
    return e;
  endfunction

  task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
    if (got !== expected) begin
      errors++;
      $display("error at %0t: %s, got %0d expected %0d", $time, what, got, expected);
      $display("Done: errors found");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic hold_bus(input logic level, input int clocks);
    dht_bus = level;
    repeat (clocks) @(negedge clock);
  endtask

  // 8N1 byte sent lsb first and followed by two idle bits
  task automatic send_byte(input logic [7:0] data, input logic stop_bit);
    logic [9:0] bits;
    bits = {stop_bit, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rx_serial = bits[i];
      repeat (CLKS_PER_BIT) @(negedge clock);
    end
    rx_serial = 1'b1;
    repeat (2 * CLKS_PER_BIT) @(negedge clock);
  endtask

  task automatic send_config(input config_t c, input logic last_stop);
    for (int i = 0; i < 4; i++) send_byte(c.lim_temp[i], 1'b1);
    send_byte(c.lim_umidade, last_stop);
  endtask

  task automatic make_limits(output config_t c);
    logic [7:0] lim;
    lim = 8'(15 + $urandom % 10);
    for (int i = 0; i < 4; i++) begin
      c.lim_temp[i] = lim;
      lim = lim + 8'(2 + $urandom % 6);
    end
    c.lim_umidade = 8'(30 + $urandom % 40);
  endtask

  // each sensor bit is a low phase then a high phase coded by width
  task automatic drive_frame(input logic [7:0] hum, input logic [7:0] temp,
                             input logic bad_sum);
    logic [7:0]  hum_dec;
    logic [7:0]  temp_dec;
    logic [7:0]  sum;
    logic [39:0] bits;
    hum_dec  = 8'($urandom % 10);
    temp_dec = 8'($urandom % 10);
    sum      = hum + hum_dec + temp + temp_dec;
    if (bad_sum) sum = sum ^ 8'h5a;
    bits = {hum, hum_dec, temp, temp_dec, sum};
    for (int i = 39; i >= 0; i--) begin
      hold_bus(1'b0, LOW_CLKS);
      hold_bus(1'b1, bits[i] ? HIGH1_CLKS : HIGH0_CLKS);
    end
    hold_bus(1'b0, LOW_CLKS);
    dht_bus = 1'b1;
  endtask

  task automatic wait_window();
    int waited;
    waited = 0;
    while (u_dut.medir !== 1'b1) begin
      @(negedge clock);
      waited++;
      if (waited > PERIODO_DELAY + TIMEOUT + 100) abort_run("no measurement request seen");
    end
  endtask

  task automatic wait_error_flag();
    int waited;
    waited = 0;
    while (erro_medida !== 1'b1) begin
      @(negedge clock);
      waited++;
      if (waited > TIMEOUT + 100) abort_run("erro_medida did not rise on a silent sensor");
    end
  endtask

  task automatic count_high(input logic servo, input int window, output int n);
    n = 0;
    repeat (window) begin
      @(negedge clock);
      if (servo ? pwm_servo : pwm_ventoinha) n++;
    end
  endtask

  task automatic measure_and_check(input logic [7:0] hum, input logic [7:0] temp);
    expected_t e;
    int        n;
    wait_window();
    drive_frame(hum, temp, 1'b0);
    last_hum  = hum;
    last_temp = temp;
    e = predict_outputs(cur_cfg, temp, hum, gira);
    check_equal(erro_medida, 0, "erro_medida after a good frame");
    check_equal(nivel_temperatura, e.nivel, "temperature level");
    check_equal(rele, e.rele, "humidifier relay");
    // duty is taken at the next period start
    repeat (2 * PWM_PERIOD) @(negedge clock);
    count_high(1'b0, PWM_PERIOD, n);
    check_equal(n, e.fan_high, "fan high clocks per period");
  endtask

  initial begin : main_seq
    int unsigned seed;
    int          n;
    expected_t   e;
    config_t     new_cfg;
    logic [7:0]  hum;
    seed      = 32'he6725e33;
    n         = $urandom(seed);
    rst_n     = 1'b0;
    start     = 1'b0;
    gira      = 1'b0;
    rx_serial = 1'b1;
    dht_bus   = 1'b1;
    cur_cfg   = CONFIG_RESET;
    last_temp = '0;
    last_hum  = '0;
    repeat (5) @(negedge clock);
    rst_n = 1'b1;
    check_equal(nivel_temperatura, 0, "level after reset");
    check_equal({erro_config, erro_medida, rele, pwm_ventoinha, pwm_servo}, 0,
                "flags and pwm outputs after reset");

    // servo width is counted over whole periods before the measure loop runs
    for (int g = 0; g < 2; g++) begin
      gira = g[0];
      e = predict_outputs(cur_cfg, 8'd0, 8'd0, gira);
      repeat (2 * SERVO_PERIOD) @(negedge clock);
      count_high(1'b1, SERVO_PERIOD, n);
      check_equal(n, e.servo_high, "servo high clocks per period");
    end

    make_limits(new_cfg);
    send_config(new_cfg, 1'b1);
    cur_cfg = new_cfg;
    check_equal(erro_config, 0, "erro_config after a good frame");
    start = 1'b1;
    @(negedge clock);
    start = 1'b0;

    for (int i = 0; i < 8; i++) begin
      measure_and_check(8'($urandom % 100), (i == 7) ? cur_cfg.lim_temp[2] : 8'($urandom % 60));
      if (i == 5) begin
        measure_and_check(cur_cfg.lim_umidade, 8'($urandom % 60));
        i++;
      end
    end

    // bad checksum keeps the old level
    wait_window();
    drive_frame(8'd10, cur_cfg.lim_temp[3] + 8'd3, 1'b1);
    e = predict_outputs(cur_cfg, last_temp, last_hum, gira);
    check_equal(erro_medida, 1, "erro_medida after a bad checksum");
    check_equal(nivel_temperatura, e.nivel, "level kept after a bad checksum");
    measure_and_check(8'($urandom % 100), 8'($urandom % 60));

    wait_window();
    wait_error_flag();
    e = predict_outputs(cur_cfg, last_temp, last_hum, gira);
    check_equal(nivel_temperatura, e.nivel, "level kept after a sensor timeout");
    hum = 8'($urandom % 100);
    measure_and_check(hum, cur_cfg.lim_temp[3] + 8'd5);

    // new limits above the temperature drop the level to 0
    for (int i = 0; i < 4; i++) new_cfg.lim_temp[i] = last_temp + 8'(i + 1);
    new_cfg.lim_umidade = last_hum + 8'd1;
    send_config(new_cfg, 1'b0);
    e = predict_outputs(cur_cfg, last_temp, last_hum, gira);
    check_equal(erro_config, 1, "erro_config after a low stop bit");
    check_equal(nivel_temperatura, e.nivel, "old limits kept after a bad frame");
    check_equal(rele, e.rele, "old humidity limit kept after a bad frame");
    send_config(new_cfg, 1'b1);
    cur_cfg = new_cfg;
    e = predict_outputs(cur_cfg, last_temp, last_hum, gira);
    check_equal(erro_config, 0, "erro_config after a following good frame");
    check_equal(nivel_temperatura, e.nivel, "level with the new limits");
    check_equal(rele, e.rele, "relay with the new humidity limit");

    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- logic/tusca.sv
module tusca
  import tusca_pkg::*;
(
  input  logic       clock,
  input  logic       rst_n,
  input  logic       start,
  input  logic       gira,
  input  logic       rx_serial,
  input  logic       dht_bus,
  output logic       erro_config,
  output logic       rele,
  output logic       pwm_ventoinha,
  output logic       pwm_servo,
  output logic       erro_medida,
  output logic [2:0] nivel_temperatura
);

  config_t cfg;
  medida_t medida;
  medida_t medida_atual;
  logic    medir;
  logic    pronto_medida;
  logic    erro_leitura;

  config_receiver rx_cfg (
    .clock(clock), .rst_n(rst_n), .rx_serial(rx_serial),
    .cfg(cfg), .erro_config(erro_config)
  );

  dht11_reader dht (
    .clock(clock), .rst_n(rst_n), .medir(medir), .dht_bus(dht_bus),
    .medida(medida), .pronto_medida(pronto_medida), .erro_leitura(erro_leitura)
  );

  tusca_uc uc (
    .clock(clock), .rst_n(rst_n), .start(start),
    .pronto_medida(pronto_medida), .erro_leitura(erro_leitura), .medida(medida),
    .medir(medir), .medida_atual(medida_atual), .erro_medida(erro_medida)
  );

  climate_actuator atuador (
    .clock(clock), .rst_n(rst_n), .medida_atual(medida_atual), .cfg(cfg),
    .gira(gira), .nivel_temperatura(nivel_temperatura),
    .pwm_ventoinha(pwm_ventoinha), .pwm_servo(pwm_servo), .rele(rele)
  );

endmodule

//--- logic/climate_actuator.sv
module climate_actuator
  import tusca_pkg::*;
(
  input  logic       clock,
  input  logic       rst_n,
  input  medida_t    medida_atual,
  input  config_t    cfg,
  input  logic       gira,
  output logic [2:0] nivel_temperatura,
  output logic       pwm_ventoinha,
  output logic       pwm_servo,
  output logic       rele
);

  logic               gira_meta;
  logic               gira_sync;
  logic [2:0]         nivel_calc;
  logic [PWM_W-1:0]   pwm_cnt;
  logic [PWM_W-1:0]   duty;
  logic [SERVO_W-1:0] servo_cnt;
  logic [SERVO_W-1:0] servo_alto;

  // number of limits already reached
  always_comb begin
    nivel_calc = '0;
    for (int i = 0; i < 4; i++) begin
      if (cfg.lim_temp[i] <= medida_atual.temperatura) begin
        nivel_calc = nivel_calc + 3'd1;
      end
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      gira_meta         <= 1'b0;
      gira_sync         <= 1'b0;
      nivel_temperatura <= '0;
      rele              <= 1'b0;
      pwm_cnt           <= '0;
      duty              <= '0;
      pwm_ventoinha     <= 1'b0;
      servo_cnt         <= '0;
      servo_alto        <= SERVO_W'(SERVO_MIN);
      pwm_servo         <= 1'b0;
    end else begin
      gira_meta         <= gira;
      gira_sync         <= gira_meta;
      nivel_temperatura <= nivel_calc;
      rele              <= (medida_atual.umidade < cfg.lim_umidade);

      // duty and servo width only change at a period boundary
      if (pwm_cnt == PWM_W'(PWM_PERIOD - 1)) begin
        pwm_cnt <= '0;
        duty    <= PWM_W'(nivel_temperatura * DUTY_STEP);
      end else begin
        pwm_cnt <= pwm_cnt + 1'b1;
      end
      pwm_ventoinha <= (pwm_cnt < duty);

      if (servo_cnt == SERVO_W'(SERVO_PERIOD - 1)) begin
        servo_cnt  <= '0;
        servo_alto <= gira_sync ? SERVO_W'(SERVO_MAX) : SERVO_W'(SERVO_MIN);
      end else begin
        servo_cnt <= servo_cnt + 1'b1;
      end
      pwm_servo <= (servo_cnt < servo_alto);
    end
  end

endmodule

//--- logic/tusca_uc.sv
module tusca_uc
  import tusca_pkg::*;
(
  input  logic    clock,
  input  logic    rst_n,
  input  logic    start,
  input  logic    pronto_medida,
  input  logic    erro_leitura,
  input  medida_t medida,
  output logic    medir,
  output medida_t medida_atual,
  output logic    erro_medida
);

  uc_state_t          state;
  logic               start_q;
  logic               start_sobe;
  logic [DELAY_W-1:0] delay_cnt;

  assign start_sobe = start & ~start_q;
  assign medir      = (state == UC_MEDIR);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      start_q   <= 1'b0;
      state     <= UC_IDLE;
      delay_cnt <= '0;
    end else begin
      start_q <= start;
      case (state)
        UC_IDLE: begin
          if (start_sobe) state <= UC_MEDIR;
        end
        UC_MEDIR: begin
          state <= UC_AGUARDA_MEDIDA;
        end
        UC_AGUARDA_MEDIDA: begin
          if (pronto_medida || erro_leitura) begin
            delay_cnt <= '0;
            state     <= UC_ESPERA;
          end
        end
        // loops back to MEDIR until reset
        UC_ESPERA: begin
          if (delay_cnt == DELAY_W'(PERIODO_DELAY - 1)) begin
            state <= UC_MEDIR;
          end else begin
            delay_cnt <= delay_cnt + 1'b1;
          end
        end
        default: state <= UC_IDLE;
      endcase
    end
  end

  // a failed reading keeps the last good value
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      medida_atual <= '0;
      erro_medida  <= 1'b0;
    end else if (pronto_medida) begin
      medida_atual <= medida;
      erro_medida  <= 1'b0;
    end else if (erro_leitura) begin
      erro_medida <= 1'b1;
    end
  end

endmodule

//--- logic/config_receiver.sv
module config_receiver
  import tusca_pkg::*;
(
  input  logic    clock,
  input  logic    rst_n,
  input  logic    rx_serial,
  output config_t cfg,
  output logic    erro_config
);

  rx_state_t         state;
  logic              rx_meta;
  logic              rx_sync;
  logic [BAUD_W-1:0] baud_cnt;
  logic [2:0]        bit_cnt;
  logic [2:0]        byte_cnt;
  logic [7:0]        rx_byte;
  config_t           staging;
  logic              baud_fim;
  logic              meio_bit;
  logic              stop_ok;
  logic              frame_ok;

  assign baud_fim = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));
  assign meio_bit = (baud_cnt == BAUD_W'(CLKS_PER_BIT / 2 - 1));
  assign stop_ok  = (state == RX_STOP) && baud_fim && rx_sync;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta     <= 1'b1;
      rx_sync     <= 1'b1;
      state       <= RX_IDLE;
      baud_cnt    <= '0;
      bit_cnt     <= '0;
      byte_cnt    <= '0;
      frame_ok    <= 1'b0;
      erro_config <= 1'b0;
      cfg         <= CONFIG_RESET;
    end else begin
      rx_meta  <= rx_serial;
      rx_sync  <= rx_meta;
      frame_ok <= stop_ok && (byte_cnt == 3'd4);
      baud_cnt <= (state == RX_IDLE || baud_fim) ? '0 : baud_cnt + 1'b1;
      if (frame_ok) begin
        cfg         <= staging;
        erro_config <= 1'b0;
      end

      case (state)
        RX_IDLE: begin
          if (!rx_sync) state <= RX_START;
        end
        // recheck the start bit at mid period, then sample data mid bit
        RX_START: begin
          if (meio_bit) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_sync ? RX_IDLE : RX_DADOS;
          end
        end
        RX_DADOS: begin
          if (baud_fim) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (baud_fim) begin
            state <= RX_IDLE;
            if (!rx_sync) begin
              erro_config <= 1'b1;
              byte_cnt    <= '0;
            end else begin
              byte_cnt <= (byte_cnt == 3'd4) ? 3'd0 : byte_cnt + 1'b1;
            end
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // lsb first on the line; bytes are lim_temp[0..3] then lim_umidade
  always_ff @(posedge clock) begin
    if (state == RX_DADOS && baud_fim) rx_byte <= {rx_sync, rx_byte[7:1]};
    if (stop_ok) begin
      if (byte_cnt == 3'd4) staging.lim_umidade <= rx_byte;
      else staging.lim_temp[byte_cnt[1:0]] <= rx_byte;
    end
  end

endmodule

//--- logic/dht11_reader.sv
module dht11_reader
  import tusca_pkg::*;
(
  input  logic    clock,
  input  logic    rst_n,
  input  logic    medir,
  input  logic    dht_bus,
  output medida_t medida,
  output logic    pronto_medida,
  output logic    erro_leitura
);

  dht_state_t           state;
  logic                 bus_meta;
  logic                 bus_sync;
  logic                 bus_prev;
  logic                 borda_desce;
  logic                 borda_sobe;
  logic [TIMEOUT_W-1:0] wdog;
  logic [5:0]           bit_cnt;
  logic [38:0]          frame;
  logic [39:0]          frame_next;
  logic                 bit_val;
  logic [7:0]           soma;
  logic                 ultimo_bit;

  assign borda_desce = bus_prev & ~bus_sync;
  assign borda_sobe  = ~bus_prev & bus_sync;

  // the watchdog restarts on every edge, so at the falling edge it holds the high width less one
  assign bit_val    = (wdog >= TIMEOUT_W'(BIT_THRESH));
  assign frame_next = {frame, bit_val};
  assign soma       = frame_next[39:32] + frame_next[31:24] + frame_next[23:16]
                    + frame_next[15:8];
  assign ultimo_bit = (state == DHT_MEDE_ALTO) && borda_desce && (bit_cnt == 6'd39);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      bus_meta      <= 1'b1;
      bus_sync      <= 1'b1;
      bus_prev      <= 1'b1;
      state         <= DHT_IDLE;
      wdog          <= '0;
      bit_cnt       <= '0;
      pronto_medida <= 1'b0;
      erro_leitura  <= 1'b0;
    end else begin
      bus_meta      <= dht_bus;
      bus_sync      <= bus_meta;
      bus_prev      <= bus_sync;
      pronto_medida <= 1'b0;
      erro_leitura  <= 1'b0;

      if (borda_sobe || borda_desce) begin
        wdog <= '0;
      end else if (state != DHT_IDLE) begin
        wdog <= wdog + 1'b1;
      end

      case (state)
        DHT_IDLE: begin
          if (medir) begin
            state   <= DHT_ESPERA_BORDA;
            bit_cnt <= '0;
            wdog    <= '0;
          end
        end
        // wait out the low phase of a bit
        DHT_ESPERA_BORDA: begin
          if (borda_sobe) begin
            state <= DHT_MEDE_ALTO;
          end
        end
        DHT_MEDE_ALTO: begin
          if (borda_desce) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (ultimo_bit) begin
              state         <= DHT_IDLE;
              pronto_medida <= (frame_next[7:0] == soma);
              erro_leitura  <= (frame_next[7:0] != soma);
            end else begin
              state <= DHT_ESPERA_BORDA;
            end
          end
        end
        default: state <= DHT_IDLE;
      endcase

      if (state != DHT_IDLE && wdog == TIMEOUT_W'(TIMEOUT - 1)) begin
        state        <= DHT_IDLE;
        erro_leitura <= 1'b1;
      end
    end
  end

  // bytes arrive msb first as umidade int, umidade dec, temp int, temp dec and checksum
  always_ff @(posedge clock) begin
    if (state == DHT_MEDE_ALTO && borda_desce) begin
      frame <= frame_next[38:0];
    end
    if (ultimo_bit) begin
      medida <= '{umidade: frame_next[39:32], temperatura: frame_next[23:16]};
    end
  end

endmodule

//--- logic/tusca_pkg.sv
package tusca_pkg;

  // timing, scaled down for simulation
  localparam int CLKS_PER_BIT  = 16;
  localparam int PERIODO_DELAY = 4000;
  localparam int TIMEOUT       = 3000;
  localparam int BIT_THRESH    = 40;

  // fan and servo pwm
  localparam int PWM_PERIOD   = 100;
  localparam int DUTY_STEP    = 25;
  localparam int SERVO_PERIOD = 400;
  localparam int SERVO_MIN    = 20;
  localparam int SERVO_MAX    = 40;

  // counter widths
  localparam int BAUD_W    = $clog2(CLKS_PER_BIT);
  localparam int DELAY_W   = $clog2(PERIODO_DELAY);
  localparam int TIMEOUT_W = $clog2(TIMEOUT);
  localparam int PWM_W     = $clog2(PWM_PERIOD + 1);
  localparam int SERVO_W   = $clog2(SERVO_PERIOD + 1);

  typedef enum logic [1:0] {UC_IDLE, UC_MEDIR, UC_AGUARDA_MEDIDA, UC_ESPERA} uc_state_t;
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DADOS, RX_STOP} rx_state_t;
  typedef enum logic [1:0] {DHT_IDLE, DHT_ESPERA_BORDA, DHT_MEDE_ALTO} dht_state_t;

  // integer percent and degrees
  typedef struct packed {
    logic [7:0] umidade;
    logic [7:0] temperatura;
  } medida_t;

  // lim_temp[0] is the lowest limit
  typedef struct packed {
    logic [3:0][7:0] lim_temp;
    logic [7:0]      lim_umidade;
  } config_t;

  localparam config_t CONFIG_RESET = '{
    lim_temp:    {8'd35, 8'd30, 8'd25, 8'd20},
    lim_umidade: 8'd50
  };

endpackage
